/* hdl/simd_alu_settings.svh */
//////////////////////////////////////////////////////////////////////
// SIMD ALU width settings
// Datapath width in bits and in bytes
//////////////////////////////////////////////////////////////////////

`ifndef SIMD_ALU_SETTINGS_SVH
`define SIMD_ALU_SETTINGS_SVH

// Datapath width in bits
`define SIMD_ALU_ELEN 64

// One strobe bit per datapath byte
`define SIMD_ALU_STRB (`SIMD_ALU_ELEN / 8)

`endif

/* hdl/simd_alu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU data types
// Operand words, packed lane views and byte strobes
//////////////////////////////////////////////////////////////////////

`include "simd_alu_settings.svh"

package simd_alu_pkg;

  // Full operand or result word
  typedef logic [`SIMD_ALU_ELEN-1:0] elen_t;

  // One flag per byte of a word
  typedef logic [`SIMD_ALU_STRB-1:0] strb_t;

  // Element values
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] half_t;
  typedef logic [31:0] word_t;

  // One word seen as packed elements of each width
  typedef union packed {
    elen_t [0:0] w64;
    word_t [1:0] w32;
    half_t [3:0] w16;
    byte_t [7:0] w8;
  } lanes_t;

endpackage

/* hdl/simd_alu_op_pkg.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU command encodings
// Opcodes and element widths of a request
//////////////////////////////////////////////////////////////////////

package simd_alu_op_pkg;

  typedef enum logic [4:0] {
    // Bitwise logic
    VAND   = 5'd0,
    VOR    = 5'd1,
    VXOR   = 5'd2,
    // Wrapping arithmetic
    VADD   = 5'd3,
    VSUB   = 5'd4,
    VRSUB  = 5'd5,
    // Saturating arithmetic
    VSADDU = 5'd6,
    VSADD  = 5'd7,
    VSSUBU = 5'd8,
    VSSUB  = 5'd9,
    // Shifts
    VSLL   = 5'd10,
    VSRL   = 5'd11,
    VSRA   = 5'd12,
    // Min and max
    VMIN   = 5'd13,
    VMINU  = 5'd14,
    VMAX   = 5'd15,
    VMAXU  = 5'd16,
    // Compares, result in bit 0 of each element
    VMSEQ  = 5'd17,
    VMSNE  = 5'd18,
    VMSLT  = 5'd19,
    VMSLTU = 5'd20
  } alu_op_e;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

endpackage

/* hdl/simd_alu_if.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU stream interfaces
// Request stream into the lanes and result stream out of them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface alu_req_if
  import simd_alu_pkg::*;
  import simd_alu_op_pkg::*;
();

  logic    valid;
  logic    ready;
  alu_op_e op;
  vew_e    vew;
  elen_t   opa;
  elen_t   opb;
  // Decoded once in the issue stage
  logic    is_signed;

  modport source (output valid, op, vew, opa, opb, is_signed, input ready);
  modport sink   (input valid, op, vew, opa, opb, is_signed, output ready);

endinterface

interface alu_res_if
  import simd_alu_pkg::*;
();

  logic  valid;
  logic  ready;
  elen_t result;
  // Per byte saturation flags
  strb_t vxsat;

  modport source (output valid, result, vxsat, input ready);
  modport sink   (input valid, result, vxsat, output ready);

endinterface

/* hdl/simd_alu_issue.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU issue stage
// Registers accepted requests and decodes operand signedness
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module simd_alu_issue
  import simd_alu_pkg::*;
  import simd_alu_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      in_valid_i,
  input  alu_op_e   op_i,
  input  vew_e      vew_i,
  input  elen_t     opa_i,
  input  elen_t     opb_i,
  output logic      in_ready_o,
  alu_req_if.source req
);

  logic    valid_q;
  alu_op_e op_q;
  vew_e    vew_q;
  elen_t   opa_q;
  elen_t   opb_q;
  logic    signed_q;
  logic    accept;
  logic    is_signed;

  // Free when empty or when the held item leaves this cycle
  assign in_ready_o = ~valid_q | req.ready;
  assign accept     = in_valid_i & in_ready_o;

  // Only these ops compare as two's complement
  assign is_signed = op_i inside {VMIN, VMAX, VMSLT};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= op_i;
      vew_q    <= vew_i;
      opa_q    <= opa_i;
      opb_q    <= opb_i;
      signed_q <= is_signed;
    end
  end

  assign req.valid     = valid_q;
  assign req.op        = op_q;
  assign req.vew       = vew_q;
  assign req.opa       = opa_q;
  assign req.opb       = opb_q;
  assign req.is_signed = signed_q;

endmodule

/* hdl/simd_alu_lanes.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU lanes
// Combinational datapath for packed 8, 16, 32 and 64 bit elements
// with per byte saturation flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "simd_alu_settings.svh"

module simd_alu_lanes
  import simd_alu_pkg::*;
  import simd_alu_op_pkg::*;
(
  alu_req_if.sink   req,
  alu_res_if.source res
);

  lanes_t opa;
  lanes_t opb;

  // Candidate results, one per element width
  elen_t  cand_res [4];
  strb_t  cand_sat [4];

  assign opa = req.opa;
  assign opb = req.opb;

  //////////////////////////////////////////////////////////////////////
  // Element datapath, built once per element width
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < 4; g++) begin : g_ew
    localparam int unsigned W  = 8 << g;
    localparam int unsigned N  = `SIMD_ALU_ELEN / W;
    localparam int unsigned SW = $clog2(W);
    localparam logic [W-1:0] SMAX = {1'b0, {(W-1){1'b1}}};
    localparam logic [W-1:0] SMIN = {1'b1, {(W-1){1'b0}}};

    for (genvar e = 0; e < N; e++) begin : g_el
      logic [W-1:0]  a;
      logic [W-1:0]  b;
      logic [W-1:0]  y;
      logic [W:0]    sum;
      logic [W:0]    dif;
      logic [SW-1:0] shamt;
      logic          less;
      logic          equal;
      logic          ovf_add;
      logic          ovf_sub;
      logic          sat;

      // Element view of both operands
      if (g == 0) begin : g_w8
        assign a = opa.w8[e];
        assign b = opb.w8[e];
      end else if (g == 1) begin : g_w16
        assign a = opa.w16[e];
        assign b = opb.w16[e];
      end else if (g == 2) begin : g_w32
        assign a = opa.w32[e];
        assign b = opb.w32[e];
      end else begin : g_w64
        assign a = opa.w64[e];
        assign b = opb.w64[e];
      end

      // Carry and borrow land in the extra top bit
      assign sum   = {1'b0, b} + {1'b0, a};
      assign dif   = {1'b0, b} - {1'b0, a};
      assign shamt = a[SW-1:0];
      assign equal = (a == b);

      // Extended sign bit covers both signed and unsigned b < a
      assign less = $signed({req.is_signed & b[W-1], b}) <
                    $signed({req.is_signed & a[W-1], a});

      // Signed overflow, exact result keeps the sign of b
      assign ovf_add = ~(a[W-1] ^ b[W-1]) & (sum[W-1] ^ b[W-1]);
      assign ovf_sub = (a[W-1] ^ b[W-1]) & (dif[W-1] ^ b[W-1]);

      always_comb begin
        y   = '0;
        sat = 1'b0;
        case (req.op)
          VAND:  y = a & b;
          VOR:   y = a | b;
          VXOR:  y = a ^ b;
          VADD:  y = sum[W-1:0];
          VSUB:  y = dif[W-1:0];
          VRSUB: y = a - b;
          VSADDU: begin
            sat = sum[W];
            y   = sat ? '1 : sum[W-1:0];
          end
          VSADD: begin
            sat = ovf_add;
            y   = sat ? (b[W-1] ? SMIN : SMAX) : sum[W-1:0];
          end
          VSSUBU: begin
            sat = dif[W];
            y   = sat ? '0 : dif[W-1:0];
          end
          VSSUB: begin
            sat = ovf_sub;
            y   = sat ? (b[W-1] ? SMIN : SMAX) : dif[W-1:0];
          end
          VSLL: y = b << shamt;
          VSRL: y = b >> shamt;
          VSRA: y = $signed(b) >>> shamt;
          VMIN, VMINU: y = less ? b : a;
          VMAX, VMAXU: y = less ? a : b;
          // Compare flag in bit 0, upper bits stay clear
          VMSEQ:         y[0] = equal;
          VMSNE:         y[0] = ~equal;
          VMSLT, VMSLTU: y[0] = less;
          default: ;
        endcase
      end

      assign cand_res[g][e*W +: W]     = y;
      assign cand_sat[g][e*W/8 +: W/8] = {(W/8){sat}};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Width select and handshake
  //////////////////////////////////////////////////////////////////////

  assign res.result = cand_res[req.vew];
  assign res.vxsat  = cand_sat[req.vew];

  assign res.valid = req.valid;
  assign req.ready = res.ready;

endmodule

/* hdl/simd_alu_result.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU result stage
// Output register with stall hold and sticky saturation bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module simd_alu_result
  import simd_alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  alu_res_if.sink res,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output elen_t   result_o,
  output strb_t   vxsat_o,
  input  logic    vxsat_clr_i,
  output logic    vxsat_sticky_o
);

  logic  valid_q;
  elen_t result_q;
  strb_t vxsat_q;
  logic  sticky_q;
  logic  load;
  logic  out_fire;

  // Stall reaches the issue stage in the same cycle
  assign res.ready = ~valid_q | out_ready_i;
  assign load      = res.valid & res.ready;
  assign out_fire  = valid_q & out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (res.ready) begin
      valid_q <= res.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_q <= res.result;
      vxsat_q  <= res.vxsat;
    end
  end

  // Clear beats set
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sticky_q <= 1'b0;
    end else if (vxsat_clr_i) begin
      sticky_q <= 1'b0;
    end else if (out_fire && |vxsat_q) begin
      sticky_q <= 1'b1;
    end
  end

  assign out_valid_o    = valid_q;
  assign result_o       = result_q;
  assign vxsat_o        = vxsat_q;
  assign vxsat_sticky_o = sticky_q;

endmodule

/* hdl/simd_alu.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU top level
// Issue register, lane datapath and result register in a row
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module simd_alu
  import simd_alu_pkg::*;
  import simd_alu_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Request side
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  // Result side
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output elen_t   result_o,
  output strb_t   vxsat_o,
  // Sticky saturation
  input  logic    vxsat_clr_i,
  output logic    vxsat_sticky_o
);

  alu_req_if req_if ();
  alu_res_if res_if ();

  simd_alu_issue u_issue (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (in_valid_i),
    .op_i       (op_i),
    .vew_i      (vew_i),
    .opa_i      (opa_i),
    .opb_i      (opb_i),
    .in_ready_o (in_ready_o),
    .req        (req_if.source)
  );

  simd_alu_lanes u_lanes (
    .req (req_if.sink),
    .res (res_if.source)
  );

  simd_alu_result u_result (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .res            (res_if.sink),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .result_o       (result_o),
    .vxsat_o        (vxsat_o),
    .vxsat_clr_i    (vxsat_clr_i),
    .vxsat_sticky_o (vxsat_sticky_o)
  );

endmodule

/* test/tb_clk_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PERIOD     = 100,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* test/tb_simd_alu.sv */
//////////////////////////////////////////////////////////////////////
// SIMD ALU testbench
// Random and directed requests, reference model, assertion checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_simd_alu
  import simd_alu_pkg::*;
  import simd_alu_op_pkg::*;
();

  localparam int unsigned TIMEOUT = 1000;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  logic        out_valid;
  logic        out_ready;
  logic        vxsat_clr;
  logic        vxsat_sticky;
  logic        stall_en;
  logic        aborted;
  logic        head_valid;
  alu_op_e     op;
  vew_e        vew;
  elen_t       opa;
  elen_t       opb;
  elen_t       result;
  elen_t       head_res;
  strb_t       vxsat;
  strb_t       head_sat;
  logic [71:0] exp_q[$];
  integer      seed = 32'h4677;
  int unsigned errors;
  int unsigned n_items;
  int unsigned n_tests;
  int unsigned n_failed;
  int unsigned err_mark;
  int unsigned cnt;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  simd_alu u_simd_alu (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .op_i           (op),
    .vew_i          (vew),
    .opa_i          (opa),
    .opb_i          (opb),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .result_o       (result),
    .vxsat_o        (vxsat),
    .vxsat_clr_i    (vxsat_clr),
    .vxsat_sticky_o (vxsat_sticky)
  );

  // Expected {vxsat, result} of one request
  function automatic logic [71:0] model(alu_op_e f_op, vew_e f_vew, elen_t a, elen_t b);
    int unsigned        w;
    int unsigned        sh;
    elen_t              mask;
    elen_t              ea;
    elen_t              eb;
    elen_t              y;
    elen_t              res;
    strb_t              sat;
    logic [65:0]        ua;
    logic [65:0]        ub;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] sx;
    logic signed [65:0] hi;
    bit                 s;
    w    = 8 << f_vew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 1;
    hi   = $signed({2'b00, mask >> 1});
    res  = '0;
    sat  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ea = (a >> (e * w)) & mask;
      eb = (b >> (e * w)) & mask;
      ua = {2'b00, ea};
      ub = {2'b00, eb};
      // Two's complement value of each element
      sa = $signed(ua) - (ea[w-1] ? $signed(66'd1 << w) : 66'sd0);
      sb = $signed(ub) - (eb[w-1] ? $signed(66'd1 << w) : 66'sd0);
      sh = ea & (w - 1);
      s  = 1'b0;
      y  = '0;
      case (f_op)
        VAND:   y = ea & eb;
        VOR:    y = ea | eb;
        VXOR:   y = ea ^ eb;
        VADD:   y = eb + ea;
        VSUB:   y = eb - ea;
        VRSUB:  y = ea - eb;
        VSADDU: begin
          s = (ub + ua) > {2'b00, mask};
          y = s ? mask : eb + ea;
        end
        VSSUBU: begin
          s = ub < ua;
          y = s ? '0 : eb - ea;
        end
        VSADD, VSSUB: begin
          sx = (f_op == VSADD) ? sb + sa : sb - sa;
          s  = (sx > hi) || (sx < -hi - 1);
          y  = (sx > hi) ? hi[63:0] : (sx < -hi - 1) ? ~hi[63:0] : sx[63:0];
        end
        VSLL:   y = eb << sh;
        VSRL:   y = eb >> sh;
        VSRA: begin
          sx = sb >>> sh;
          y  = sx[63:0];
        end
        VMIN:   y = (sb < sa) ? eb : ea;
        VMINU:  y = (ub < ua) ? eb : ea;
        VMAX:   y = (sb < sa) ? ea : eb;
        VMAXU:  y = (ub < ua) ? ea : eb;
        VMSEQ:  y = elen_t'(ea == eb);
        VMSNE:  y = elen_t'(ea != eb);
        VMSLT:  y = elen_t'(sb < sa);
        VMSLTU: y = elen_t'(ub < ua);
        default: y = '0;
      endcase
      res = res | ((y & mask) << (e * w));
      if (s) begin
        sat = sat | strb_t'(((1 << (w / 8)) - 1) << (e * w / 8));
      end
    end
    return {sat, res};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (in_valid && in_ready) begin
      exp_q.push_back(model(op, vew, opa, opb));
    end
    if (out_valid && out_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      n_items++;
    end
    head_valid = exp_q.size() > 0;
    {head_sat, head_res} = head_valid ? exp_q[0] : '0;
  end

  a_result: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready |-> head_valid && result == head_res && vxsat == head_sat)
    else begin
      errors++;
      $display("Error %0t: result %h vxsat %h, expected %h vxsat %h", $time,
               $sampled(result), $sampled(vxsat), $sampled(head_res), $sampled(head_sat));
    end

  a_stall: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable(vxsat))
    else begin
      errors++;
      $display("Error %0t: output changed while stalled", $time);
    end

  a_sticky_set: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready && vxsat != '0 && !vxsat_clr |=> vxsat_sticky)
    else begin
      errors++;
      $display("Error %0t: sticky bit did not set", $time);
    end

  a_sticky_hold: assert property (@(posedge clk) disable iff (!arst_n)
    vxsat_sticky && !vxsat_clr |=> vxsat_sticky)
    else begin
      errors++;
      $display("Error %0t: sticky bit dropped without a clear", $time);
    end

  a_sticky_clr: assert property (@(posedge clk) disable iff (!arst_n)
    vxsat_clr |=> !vxsat_sticky)
    else begin
      errors++;
      $display("Error %0t: sticky bit not cleared", $time);
    end

  // Random back-pressure
  always @(negedge clk) begin
    out_ready = stall_en ? (($random(seed) & 32'h3) != 0) : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  function automatic elen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic send(input alu_op_e s_op, input vew_e s_vew, input elen_t a, input elen_t b);
    int unsigned n;
    bit taken;
    if (aborted) return;
    op       = s_op;
    vew      = s_vew;
    opa      = a;
    opb      = b;
    in_valid = 1'b1;
    n        = 0;
    taken    = 1'b0;
    while (!taken && n < TIMEOUT) begin
      @(posedge clk);
      taken = in_ready;
      @(negedge clk);
      n++;
    end
    in_valid = 1'b0;
    if (!taken) begin
      $display("Timed out waiting for the DUT to accept a request");
      aborted = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int unsigned n;
    if (aborted) return;
    n = 0;
    while (exp_q.size() > 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("Timed out waiting for %0d results to leave the DUT", exp_q.size());
      aborted = 1'b1;
    end
  endtask

  task automatic run_ops(input alu_op_e first, input alu_op_e last, input int unsigned reps);
    elen_t a;
    elen_t b;
    for (int v = 0; v < 4; v++) begin
      for (int k = first; k <= last; k++) begin
        for (int unsigned r = 0; r < reps; r++) begin
          a = rand_word();
          b = (r % 4 == 3) ? a : rand_word();
          send(alu_op_e'(k), vew_e'(v), a, b);
        end
      end
    end
    wait_drain();
  endtask

  task automatic pulse_clear();
    vxsat_clr = 1'b1;
    @(negedge clk);
    vxsat_clr = 1'b0;
  endtask

  task automatic check_sticky(input logic exp);
    assert (vxsat_sticky == exp) else begin
      errors++;
      $display("Error %0t: vxsat_sticky %b, expected %b", $time, vxsat_sticky, exp);
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (errors == err_mark && !aborted) begin
      $display("test %-12s passed", name);
    end else begin
      n_failed++;
      $display("test %-12s failed", name);
    end
    err_mark = errors;
  endtask

  initial begin
    in_valid   = 1'b0;
    vxsat_clr  = 1'b0;
    stall_en   = 1'b0;
    aborted    = 1'b0;
    head_valid = 1'b0;
    out_ready  = 1'b1;
    op         = VAND;
    vew        = EW8;
    opa        = '0;
    opb        = '0;
    cnt        = 0;
    while (arst_n !== 1'b1 && cnt < 10) begin
      @(negedge clk);
      cnt++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timed out waiting for reset release");
      aborted = 1'b1;
    end
    assert (!out_valid && in_ready && !vxsat_sticky) else begin
      errors++;
      $display("Error %0t: DUT not idle after reset", $time);
    end
    finish_test("reset");
    run_ops(VAND, VRSUB, 4);
    finish_test("logic_arith");
    send(VSADDU, EW8, '1, '1);
    send(VSSUBU, EW16, '1, '0);
    send(VSADD, EW32, 64'h1, 64'h7fff_ffff_7fff_ffff);
    send(VSSUB, EW64, 64'h1, 64'h8000_0000_0000_0000);
    run_ops(VSADDU, VSSUB, 6);
    finish_test("saturate");
    run_ops(VSLL, VSRA, 6);
    finish_test("shift");
    run_ops(VMIN, VMSLTU, 6);
    finish_test("minmax_cmp");
    stall_en = 1'b1;
    run_ops(VAND, VMSLTU, 2);
    stall_en = 1'b0;
    finish_test("backpressure");
    pulse_clear();
    send(VAND, EW32, rand_word(), rand_word());
    wait_drain();
    check_sticky(1'b0);
    send(VSADDU, EW8, '1, '1);
    send(VXOR, EW8, rand_word(), rand_word());
    wait_drain();
    check_sticky(1'b1);
    pulse_clear();
    check_sticky(1'b0);
    finish_test("sticky");
    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             n_tests, n_failed, n_items, errors);
    if (errors == 0 && !aborted) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* simd_alu.f */
+incdir+hdl
hdl/simd_alu_pkg.sv
hdl/simd_alu_op_pkg.sv
hdl/simd_alu_if.sv
hdl/simd_alu_issue.sv
hdl/simd_alu_lanes.sv
hdl/simd_alu_result.sv
hdl/simd_alu.sv
test/tb_clk_gen.sv
test/tb_simd_alu.sv

/* Bender.yml */
package:
  name: simd_alu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/simd_alu_pkg.sv
      - hdl/simd_alu_op_pkg.sv
      - hdl/simd_alu_if.sv
      - hdl/simd_alu_issue.sv
      - hdl/simd_alu_lanes.sv
      - hdl/simd_alu_result.sv
      - hdl/simd_alu.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_simd_alu.sv
